//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = gfx_rom_loader_tb
FILELIST  = gfx_rom_loader.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, scan $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "TEST FAILED (simulator error)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- gfx_rom_loader.f
hdl/gfx_load_pkg.sv
hdl/rom_downloader.sv
hdl/obj_reorder.sv
hdl/gfx_word_ram.sv
hdl/gfx_rom_loader_top.sv
verification/gfx_rom_loader_tb.sv

//--- hdl/gfx_load_pkg.sv
// --------------------
// gfx_load_pkg
// request struct and widths shared by
// the graphics ROM loading path
// --------------------
package gfx_load_pkg;

    localparam int ADDR_MAX_W = 16; // widest word address a request carries
    localparam int WORD_W     = 16; // graphics memory word
    localparam int BYTE_W     = 8;  // host download byte

    // active-low byte enables, one lane per request
    localparam logic [1:0] MASK_LOW  = 2'b10; // writes bits 7:0
    localparam logic [1:0] MASK_HIGH = 2'b01; // writes bits 15:8

    // one access on the shared memory port
    // rd or we stays high until ack
    typedef struct packed {
        logic [ADDR_MAX_W-1:0] addr; // word address, low bits used
        logic [BYTE_W-1:0]     data; // byte for the enabled lane
        logic [1:0]            mask; // active low, bit 0 is the low byte
        logic                  we;
        logic                  rd;
    } mem_req_t;

endpackage

//--- hdl/gfx_rom_loader_top.sv
// --------------------
// gfx_rom_loader_top
// downloader, object converter and
// graphics memory
// --------------------
`timescale 1ns/1ps

module gfx_rom_loader_top #(
    parameter int ADDR_W    = 10,
    parameter int OBJ_START = 256,
    parameter int OBJ_END   = 512,
    parameter int READ_LAT  = 3
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              downloading,
    input  logic [gfx_load_pkg::ADDR_MAX_W:0] dl_addr,
    input  logic [gfx_load_pkg::BYTE_W-1:0]   dl_data,
    input  logic                              dl_wr,
    output logic                              dl_ready,
    output logic                              convert,
    input  logic [ADDR_W-1:0]                 fetch_addr,
    output logic [gfx_load_pkg::WORD_W-1:0]   fetch_data
);

    gfx_load_pkg::mem_req_t            load_req;
    gfx_load_pkg::mem_req_t            conv_req;
    logic                              load_ack;
    logic                              load_data_ok;
    logic                              conv_ack;
    logic                              conv_data_ok;
    logic [gfx_load_pkg::WORD_W-1:0]   rd_data;

    rom_downloader u_downloader (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .dl_addr     (dl_addr),
        .dl_data     (dl_data),
        .dl_wr       (dl_wr),
        .dl_ready    (dl_ready),
        .req         (load_req),
        .ack         (load_ack),
        .data_ok     (load_data_ok)
    );

    obj_reorder #(
        .OBJ_START (OBJ_START),
        .OBJ_END   (OBJ_END)
    ) u_reorder (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .convert     (convert),
        .req         (conv_req),
        .ack         (conv_ack),
        .data_ok     (conv_data_ok),
        .rd_data     (rd_data)
    );

    gfx_word_ram #(
        .ADDR_W   (ADDR_W),
        .READ_LAT (READ_LAT)
    ) u_ram (
        .clk          (clk),
        .reset        (reset),
        .downloading  (downloading),
        .load_req     (load_req),
        .conv_req     (conv_req),
        .load_ack     (load_ack),
        .load_data_ok (load_data_ok),
        .conv_ack     (conv_ack),
        .conv_data_ok (conv_data_ok),
        .rd_data      (rd_data),
        .fetch_addr   (fetch_addr),
        .fetch_data   (fetch_data)
    );

endmodule

//--- hdl/gfx_word_ram.sv
// --------------------
// gfx_word_ram
// 16-bit graphics memory, one shared request
// port with fixed latency and a fetch port
// --------------------
`timescale 1ns/1ps

module gfx_word_ram #(
    parameter int ADDR_W   = 10,
    parameter int READ_LAT = 3   // ack to data_ok, at least 1
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              downloading,
    input  gfx_load_pkg::mem_req_t            load_req,
    input  gfx_load_pkg::mem_req_t            conv_req,
    output logic                              load_ack,
    output logic                              load_data_ok,
    output logic                              conv_ack,
    output logic                              conv_data_ok,
    output logic [gfx_load_pkg::WORD_W-1:0]   rd_data,
    input  logic [ADDR_W-1:0]                 fetch_addr,
    output logic [gfx_load_pkg::WORD_W-1:0]   fetch_data
);

    localparam int BW = gfx_load_pkg::BYTE_W;
    localparam int WW = gfx_load_pkg::WORD_W;

    logic [WW-1:0]            mem [2**ADDR_W];
    gfx_load_pkg::mem_req_t   sel;
    logic                     accept;
    logic                     busy;       // access pending until data_ok
    logic                     ack_r;
    logic                     acc_load;   // accepted access came from the loader
    logic [ADDR_W-1:0]        acc_addr;
    logic [READ_LAT-1:0]      lat_sr;
    logic                     data_ok;

    // downloader owns the port during a download
    assign sel     = downloading ? load_req : conv_req;
    assign accept  = !busy && (sel.rd || sel.we);
    assign data_ok = lat_sr[READ_LAT-1];

    assign load_ack     = ack_r   &&  acc_load &&  downloading;
    assign conv_ack     = ack_r   && !acc_load && !downloading;
    assign load_data_ok = data_ok &&  acc_load &&  downloading;
    assign conv_data_ok = data_ok && !acc_load && !downloading;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            ack_r    <= 1'b0;
            acc_load <= 1'b0;
            lat_sr   <= '0;
        end else begin
            ack_r  <= accept;
            lat_sr <= (lat_sr << 1) | READ_LAT'(ack_r);
            if (accept) begin
                busy     <= 1'b1;
                acc_load <= downloading;
            end else if (data_ok) begin
                busy <= 1'b0;
            end
        end
    end

    // storage, writes land at acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            acc_addr <= sel.addr[ADDR_W-1:0];
            if (sel.we && !sel.mask[0]) begin
                mem[sel.addr[ADDR_W-1:0]][BW-1:0] <= sel.data;
            end
            if (sel.we && !sel.mask[1]) begin
                mem[sel.addr[ADDR_W-1:0]][WW-1:BW] <= sel.data;
            end
        end
        if (busy && !data_ok) begin
            rd_data <= mem[acc_addr]; // settles before data_ok, held after
        end
    end

    // renderer side, plain synchronous read
    always_ff @(posedge clk) begin
        fetch_data <= mem[fetch_addr];
    end

    // no earlier access may still sit in the latency pipe
    a_ack_when_idle : assert property (
        @(posedge clk) disable iff (reset)
        ack_r |-> (lat_sr == '0)
    );

    a_data_ok_latency : assert property (
        @(posedge clk) disable iff (reset)
        ack_r |-> ##READ_LAT (data_ok && busy)
    );

endmodule

//--- hdl/obj_reorder.sv
// --------------------
// obj_reorder
// rewrites the object window in place, 8-pixel
// packed 4bpp to the 4-pixel fetch layout
// --------------------
`timescale 1ns/1ps

module obj_reorder #(
    parameter int OBJ_START = 256, // first word, even
    parameter int OBJ_END   = 512  // one past the last word, even
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              downloading,
    output logic                              convert,
    output gfx_load_pkg::mem_req_t            req,
    input  logic                              ack,
    input  logic                              data_ok,
    input  logic [gfx_load_pkg::WORD_W-1:0]   rd_data
);

    localparam int AW  = gfx_load_pkg::ADDR_MAX_W;
    localparam int AW1 = AW + 1;
    localparam logic [AW:0] WIN_END = AW1'(OBJ_END);

    // one-hot steps, each names the access now in flight
    localparam int S_IDLE = 0;
    localparam int S_RD0  = 1; // even word read
    localparam int S_RD1  = 2; // odd word read
    localparam int S_WR0  = 3; // even word, low byte
    localparam int S_WR1  = 4; // even word, high byte
    localparam int S_WR2  = 5; // odd word, low byte
    localparam int S_WR3  = 6; // odd word, high byte

    logic [6:0]                       state;
    logic                             last_down;
    logic [AW-1:0]                    pair_addr; // even address of the pair
    logic [AW:0]                      next_pair;
    logic [gfx_load_pkg::WORD_W-1:0]  w0;
    logic [gfx_load_pkg::WORD_W-1:0]  w1;

    assign next_pair = {1'b0, pair_addr} + AW1'(2);

    always_ff @(posedge clk) begin
        if (reset) begin
            last_down <= 1'b0;
        end else begin
            last_down <= downloading;
        end
    end

    // a new download aborts any conversion at once
    always_ff @(posedge clk) begin
        if (reset || downloading) begin
            state   <= 7'(1) << S_IDLE;
            convert <= 1'b0;
            req.rd  <= 1'b0;
            req.we  <= 1'b0;
        end else begin
            if (ack) begin
                req.rd <= 1'b0;
                req.we <= 1'b0;
            end

            case (1'b1)
                state[S_IDLE]: if (last_down) begin // download just ended
                    pair_addr <= AW'(OBJ_START);
                    req.addr  <= AW'(OBJ_START);
                    req.rd    <= 1'b1;
                    convert   <= 1'b1;
                    state     <= 7'(1) << S_RD0;
                end
                state[S_RD0]: if (data_ok) begin
                    w0       <= rd_data;
                    req.addr <= {pair_addr[AW-1:1], 1'b1};
                    req.rd   <= 1'b1;
                    state    <= 7'(1) << S_RD1;
                end
                state[S_RD1]: if (data_ok) begin
                    w1       <= rd_data;
                    req.addr <= pair_addr;
                    req.data <= {rd_data[15:12], rd_data[7:4]}; // w1 upper nibbles
                    req.mask <= gfx_load_pkg::MASK_LOW;
                    req.we   <= 1'b1;
                    state    <= 7'(1) << S_WR0;
                end
                state[S_WR0]: if (data_ok) begin
                    req.data <= {w0[15:12], w0[7:4]};
                    req.mask <= gfx_load_pkg::MASK_HIGH;
                    req.we   <= 1'b1;
                    state    <= 7'(1) << S_WR1;
                end
                state[S_WR1]: if (data_ok) begin
                    req.addr <= {pair_addr[AW-1:1], 1'b1};
                    req.data <= {w1[11:8], w1[3:0]}; // lower nibbles
                    req.mask <= gfx_load_pkg::MASK_LOW;
                    req.we   <= 1'b1;
                    state    <= 7'(1) << S_WR2;
                end
                state[S_WR2]: if (data_ok) begin
                    req.data <= {w0[11:8], w0[3:0]};
                    req.mask <= gfx_load_pkg::MASK_HIGH;
                    req.we   <= 1'b1;
                    state    <= 7'(1) << S_WR3;
                end
                state[S_WR3]: if (data_ok) begin
                    if (next_pair >= WIN_END) begin
                        convert <= 1'b0; // window done
                        state   <= 7'(1) << S_IDLE;
                    end else begin
                        pair_addr <= next_pair[AW-1:0];
                        req.addr  <= next_pair[AW-1:0];
                        req.rd    <= 1'b1;
                        state     <= 7'(1) << S_RD0;
                    end
                end
                default: state <= 7'(1) << S_IDLE;
            endcase
        end
    end

    a_rd_we_exclusive : assert property (
        @(posedge clk) disable iff (reset)
        !(req.rd && req.we)
    );

endmodule

//--- hdl/rom_downloader.sv
// --------------------
// rom_downloader
// host byte stream to masked byte writes,
// dl_ready low while a byte is in flight
// --------------------
`timescale 1ns/1ps

module rom_downloader (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               downloading,
    input  logic [gfx_load_pkg::ADDR_MAX_W:0]  dl_addr,    // byte address
    input  logic [gfx_load_pkg::BYTE_W-1:0]    dl_data,
    input  logic                               dl_wr,
    output logic                               dl_ready,
    output gfx_load_pkg::mem_req_t             req,
    input  logic                               ack,
    input  logic                               data_ok
);

    // idle whenever no download runs, so a byte still
    // in flight at the end cannot leave dl_ready stuck low
    always_ff @(posedge clk) begin
        if (reset || !downloading) begin
            dl_ready <= 1'b1;
            req.we   <= 1'b0;
            req.rd   <= 1'b0;
        end else begin
            if (dl_wr) begin
                req.addr <= dl_addr[gfx_load_pkg::ADDR_MAX_W:1];
                req.data <= dl_data;
                // even byte is the high byte of the word
                req.mask <= dl_addr[0] ? gfx_load_pkg::MASK_LOW : gfx_load_pkg::MASK_HIGH;
                req.we   <= 1'b1;
                dl_ready <= 1'b0;
            end else if (ack) begin
                req.we <= 1'b0; // accepted, memory holds it now
            end

            if (data_ok) begin
                dl_ready <= 1'b1;
            end
        end
    end

    // host must wait for dl_ready before the next byte
    a_no_wr_when_busy : assert property (
        @(posedge clk) disable iff (reset)
        dl_wr |-> dl_ready
    );

endmodule

//--- verification/gfx_rom_loader_tb.sv
// --------------------
// gfx_rom_loader_tb
// random ROM images through download and object
// conversion, checked against a reference model
// --------------------
`timescale 1ns/1ps

module gfx_rom_loader_tb;

    localparam int ADDR_W    = 10;
    localparam int OBJ_START = 256;
    localparam int OBJ_END   = 512;
    localparam int READ_LAT  = 3;
    localparam int WORDS     = 2 ** ADDR_W;
    localparam int IMG_BYTES = 2 * WORDS;
    localparam int DL_AW     = gfx_load_pkg::ADDR_MAX_W + 1;
    localparam int BYTE_LIMIT = 8 * (READ_LAT + 4);                       // one byte in flight
    localparam int CONV_LIMIT = (OBJ_END - OBJ_START) * 3 * (READ_LAT + 4) * 2;
    localparam int WATCHDOG_CYCLES = IMG_BYTES * (2 + READ_LAT + 4) * 6;

    logic                              clk;
    logic                              reset;
    logic                              downloading;
    logic [DL_AW-1:0]                  dl_addr;
    logic [gfx_load_pkg::BYTE_W-1:0]   dl_data;
    logic                              dl_wr;
    logic                              dl_ready;
    logic                              convert;
    logic [ADDR_W-1:0]                 fetch_addr;
    logic [gfx_load_pkg::WORD_W-1:0]   fetch_data;

    logic [7:0]  image [IMG_BYTES];
    logic [15:0] ref_mem [WORDS];       // expected memory contents
    integer      seed = 32'h954f5a4f;
    int          errors;
    int          test_errors;           // error count when the current test began
    int          pass_count;
    int          fail_count;
    logic        prev_down = 1'b0;

    gfx_rom_loader_top #(
        .ADDR_W    (ADDR_W),
        .OBJ_START (OBJ_START),
        .OBJ_END   (OBJ_END),
        .READ_LAT  (READ_LAT)
    ) UUT (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .dl_addr     (dl_addr),
        .dl_data     (dl_data),
        .dl_wr       (dl_wr),
        .dl_ready    (dl_ready),
        .convert     (convert),
        .fetch_addr  (fetch_addr),
        .fetch_data  (fetch_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run exceeded %0d cycles, stopping", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // convert may lag the rise of downloading by one cycle only
    always @(posedge clk) begin
        if (!reset && downloading && prev_down) begin
            check(32'(convert), 32'(0), "convert high during a download");
        end
        prev_down <= downloading;
    end

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            pass_count++;
            $display("%s: pass", name);
        end else begin
            fail_count++;
            $display("%s: FAIL, %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    function automatic void fill_image();
        for (int i = 0; i < IMG_BYTES; i++) begin
            image[i] = 8'($random(seed));
        end
    endfunction

    // even byte lands high, then the nibble rule over the window
    function automatic void build_model();
        logic [15:0] w0;
        logic [15:0] w1;
        for (int j = 0; j < WORDS; j++) begin
            ref_mem[j] = {image[2*j], image[2*j+1]};
        end
        for (int p = OBJ_START; p < OBJ_END; p += 2) begin
            w0 = ref_mem[p];
            w1 = ref_mem[p+1];
            ref_mem[p]   = {w0[15:12], w0[7:4], w1[15:12], w1[7:4]};
            ref_mem[p+1] = {w0[11:8], w0[3:0], w1[11:8], w1[3:0]};
        end
    endfunction

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!dl_ready && cycles < BYTE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!dl_ready) begin
            errors++;
            $display("dl_ready stayed low for %0d cycles at %0t", BYTE_LIMIT, $time);
        end
    endtask

    task automatic download_image();
        int gap;
        @(posedge clk);
        downloading <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < IMG_BYTES; i++) begin
            wait_ready();
            dl_addr <= DL_AW'(i);
            dl_data <= image[i];
            dl_wr   <= 1'b1;
            @(posedge clk);
            dl_wr <= 1'b0;
            @(posedge clk);
            check(32'(dl_ready), 32'(0), "dl_ready low while a byte is in flight");
            gap = $random(seed) & 3; // idle cycles on the host side
            repeat (gap) @(posedge clk);
        end
        wait_ready();           // last byte written before the end
        downloading <= 1'b0;
    endtask

    task automatic follow_conversion();
        int cycles;
        @(posedge clk);
        check(32'(convert), 32'(0), "convert before the falling edge is seen");
        @(posedge clk);
        check(32'(convert), 32'(1), "convert one cycle after downloading falls");
        cycles = 0;
        while (convert && cycles < CONV_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (convert) begin
            errors++;
            $display("conversion still running after %0d cycles", CONV_LIMIT);
        end
    endtask

    task automatic compare_words(input int lo, input int hi);
        for (int a = lo; a < hi; a++) begin
            fetch_addr <= ADDR_W'(a);
            @(posedge clk);
            @(posedge clk);
            check(32'(fetch_data), 32'(ref_mem[a]), $sformatf("fetch word %0d", a));
        end
    endtask

    initial begin
        reset       = 1'b1;
        downloading = 1'b0;
        dl_addr     = '0;
        dl_data     = '0;
        dl_wr       = 1'b0;
        fetch_addr  = '0;
        errors      = 0;
        test_errors = 0;
        pass_count  = 0;
        fail_count  = 0;

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        check(32'(convert), 32'(0), "convert after reset");
        check(32'(dl_ready), 32'(1), "dl_ready after reset");
        end_test("reset state");

        fill_image();
        build_model();
        download_image();
        end_test("download with flow control");
        follow_conversion();
        end_test("convert timing");
        compare_words(0, OBJ_START);
        compare_words(OBJ_END, WORDS);
        end_test("readback outside window");
        compare_words(OBJ_START, OBJ_END);
        end_test("readback inside window");

        // this conversion gets cut off by the next download
        fill_image();
        download_image();
        repeat (100 + ($random(seed) & 255)) @(posedge clk);
        check(32'(convert), 32'(1), "conversion running before the new download");
        fill_image();
        build_model();
        download_image();
        follow_conversion();
        compare_words(0, WORDS);
        end_test("download during conversion");

        $display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, errors);
        if (fail_count == 0 && errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
